// ==== verilog/memPkg.sv ====
package memPkg;

    //////////////////////////////
    // Widths
    localparam int AddrBits = 17;               // 128 KiB of RAM
    localparam int DataBits = 32;
    localparam int LenBits = 2;
    localparam int TagBits = 4;

    //////////////////////////////
    // Queue and cache geometry
    localparam int QueueDepth = 4;
    localparam int QueuePtrBits = 2;
    localparam int LineCount = 16;              // One word per line
    localparam int OffsetBits = 2;
    localparam int IndexBits = 4;
    localparam int CacheTagBits = AddrBits - IndexBits - OffsetBits;

    //////////////////////////////
    // Controller timing
    localparam int MemStartDelay = 2;
    localparam int DelayBits = 2;
    localparam int MemBytes = 131072;

    typedef logic [AddrBits-1:0] addrT;
    typedef logic [DataBits-1:0] dataT;
    typedef logic [LenBits-1:0] lenT;           // 0 byte, 1 half, 3 word
    typedef logic [TagBits-1:0] tagT;
    typedef logic [IndexBits-1:0] indexT;
    typedef logic [CacheTagBits-1:0] cacheTagT;
    typedef logic [DelayBits-1:0] delayCntT;

    typedef enum logic [1:0] {cacheIdle, cacheLookup, cacheMemWait, cacheRespond} cacheStateT;
    typedef enum logic [1:0] {memIdle, memDelay, memTransfer} memStateT;

endpackage

// ==== verilog/memReqIf.sv ====
`timescale 1ns/1ps

interface memReqIf import memPkg::*; ();
    logic en;
    logic ls;                   // 1 for store
    addrT addr;
    dataT data;
    lenT len;
    tagT tag;

    logic ready;
    logic done;                 // One cycle per request
    dataT rdata;
    tagT rtag;

    modport queue (
        output en, ls, addr, data, len, tag,
        input  ready, done, rdata, rtag
    );

    modport cache (
        input  en, ls, addr, data, len, tag,
        output ready, done, rdata, rtag
    );
endinterface

// ==== verilog/memBusIf.sv ====
`timescale 1ns/1ps

interface memBusIf import memPkg::*; ();
    logic en;                   // Single cycle start
    logic ls;
    addrT addr;
    dataT data;
    lenT len;

    logic busy;
    logic done;
    dataT rdata;

    modport cache (
        output en, ls, addr, data, len,
        input  busy, done, rdata
    );

    modport ctrl (
        input  en, ls, addr, data, len,
        output busy, done, rdata
    );
endinterface

// ==== verilog/loadStoreQueue.sv ====
`timescale 1ns/1ps

module loadStoreQueue import memPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   reqValid,
    input  logic   reqStore,
    input  addrT   reqAddr,
    input  dataT   reqData,
    input  lenT    reqLen,
    input  tagT    reqTag,
    output logic   reqReady,
    output logic   respValid,
    output dataT   respData,
    output tagT    respTag,
    memReqIf.queue cacheReq
);
    logic entLs [QueueDepth];
    addrT entAddr [QueueDepth];
    dataT entData [QueueDepth];
    lenT entLen [QueueDepth];
    tagT entTag [QueueDepth];

    logic [QueuePtrBits-1:0] wrPtr;
    logic [QueuePtrBits-1:0] rdPtr;
    logic [QueuePtrBits:0] count;
    logic push;
    logic pop;

    assign reqReady = (count != (QueuePtrBits+1)'(QueueDepth));
    assign push = reqValid && reqReady;
    assign pop = cacheReq.en && cacheReq.ready;

    // Head entry goes to the cache
    assign cacheReq.en = (count != '0);
    assign cacheReq.ls = entLs[rdPtr];
    assign cacheReq.addr = entAddr[rdPtr];
    assign cacheReq.data = entData[rdPtr];
    assign cacheReq.len = entLen[rdPtr];
    assign cacheReq.tag = entTag[rdPtr];

    assign respValid = cacheReq.done;           // Pass straight through
    assign respData = cacheReq.rdata;
    assign respTag = cacheReq.rtag;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push)
                wrPtr <= wrPtr + 1'b1;          // Wraps at depth
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entLs[wrPtr] <= reqStore;
            entAddr[wrPtr] <= reqAddr;
            entData[wrPtr] <= reqData;
            entLen[wrPtr] <= reqLen;
            entTag[wrPtr] <= reqTag;
        end
    end

endmodule

// ==== verilog/dataCache.sv ====
`timescale 1ns/1ps

module dataCache import memPkg::*; (
    input  logic   clk,
    input  logic   rst,
    memReqIf.cache cpuSide,
    memBusIf.cache memSide
);
    cacheStateT state;

    // Held request
    logic reqLs;
    addrT reqAddr;
    dataT reqData;
    lenT reqLen;
    tagT reqTag;
    dataT respData;

    logic [LineCount-1:0] lineValid;
    cacheTagT lineTags [LineCount];
    dataT lineData [LineCount];

    cacheTagT addrTag;
    indexT addrIndex;
    logic [OffsetBits-1:0] addrOffset;
    logic hit;
    logic loadHit;

    function automatic dataT lenMask(lenT len);
        case (len)
            2'd0: return 32'h0000_00ff;
            2'd1: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic dataT selectBytes(dataT word, logic [OffsetBits-1:0] offset, lenT len);
        return (word >> {offset, 3'b000}) & lenMask(len);    // Zero extended
    endfunction

    function automatic dataT mergeBytes(dataT word, dataT wdata,
                                        logic [OffsetBits-1:0] offset, lenT len);
        dataT mask;
        mask = lenMask(len) << {offset, 3'b000};
        return (word & ~mask) | ((wdata & lenMask(len)) << {offset, 3'b000});
    endfunction

    assign addrTag = reqAddr[AddrBits-1 -: CacheTagBits];
    assign addrIndex = reqAddr[OffsetBits +: IndexBits];
    assign addrOffset = reqAddr[OffsetBits-1:0];
    assign hit = lineValid[addrIndex] && (lineTags[addrIndex] == addrTag);
    assign loadHit = hit && !reqLs;

    assign cpuSide.ready = (state == cacheIdle);
    assign cpuSide.done = (state == cacheRespond);
    assign cpuSide.rdata = respData;
    assign cpuSide.rtag = reqTag;

    // Misses read the whole aligned word, stores write through as given
    assign memSide.en = (state == cacheLookup) && !loadHit && !memSide.busy;
    assign memSide.ls = reqLs;
    assign memSide.addr = reqLs ? reqAddr : {reqAddr[AddrBits-1:OffsetBits], {OffsetBits{1'b0}}};
    assign memSide.data = reqData;
    assign memSide.len = reqLs ? reqLen : lenT'(3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cacheIdle;
            lineValid <= '0;
        end else begin
            case (state)
                cacheIdle: if (cpuSide.en) state <= cacheLookup;
                cacheLookup: begin
                    if (loadHit)
                        state <= cacheRespond;
                    else if (memSide.en)
                        state <= cacheMemWait;
                end
                cacheMemWait: begin
                    if (memSide.done) begin
                        state <= cacheRespond;
                        if (!reqLs)
                            lineValid[addrIndex] <= 1'b1;   // Refill
                    end
                end
                default: state <= cacheIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpuSide.en && cpuSide.ready) begin
            reqLs <= cpuSide.ls;
            reqAddr <= cpuSide.addr;
            reqData <= cpuSide.data;
            reqLen <= cpuSide.len;
            reqTag <= cpuSide.tag;
        end
        if (state == cacheLookup && loadHit)
            respData <= selectBytes(lineData[addrIndex], addrOffset, reqLen);
        if (state == cacheMemWait && memSide.done) begin
            if (reqLs) begin
                respData <= '0;
                if (hit)                            // No allocate on store miss
                    lineData[addrIndex] <= mergeBytes(lineData[addrIndex], reqData,
                                                      addrOffset, reqLen);
            end else begin
                respData <= selectBytes(memSide.rdata, addrOffset, reqLen);
                lineData[addrIndex] <= memSide.rdata;
                lineTags[addrIndex] <= addrTag;
            end
        end
    end

endmodule

// ==== verilog/memController.sv ====
`timescale 1ns/1ps

module memController import memPkg::*; (
    input  logic  clk,
    input  logic  rst,
    memBusIf.ctrl bus
);
    logic [7:0] ram [MemBytes];

    memStateT state;
    delayCntT delayCnt;
    lenT remaining;                 // Bytes left after this one
    logic done;

    logic ls;
    lenT lastIdx;
    addrT curAddr;
    dataT wdata;
    dataT rdata;
    logic [OffsetBits-1:0] byteIdx;

    initial begin
        for (int i = 0; i < MemBytes; i++)
            ram[i] = 8'h00;
    end

    assign byteIdx = lastIdx - remaining;       // Little endian byte lane
    assign bus.busy = (state != memIdle) || done;
    assign bus.done = done;
    assign bus.rdata = rdata;

    //////////////////////////////
    // Sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memIdle;
            delayCnt <= '0;
            remaining <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                memIdle: begin
                    if (bus.en) begin
                        state <= memDelay;
                        delayCnt <= delayCntT'(MemStartDelay - 1);
                        remaining <= bus.len;
                    end
                end
                memDelay: begin
                    if (delayCnt == '0)
                        state <= memTransfer;
                    else
                        delayCnt <= delayCnt - 1'b1;
                end
                memTransfer: begin
                    if (remaining == '0) begin
                        state <= memIdle;
                        done <= 1'b1;
                    end else begin
                        remaining <= remaining - 1'b1;
                    end
                end
                default: state <= memIdle;
            endcase
        end
    end

    //////////////////////////////
    // Byte datapath
    always_ff @(posedge clk) begin
        if (state == memIdle && bus.en) begin
            ls <= bus.ls;
            lastIdx <= bus.len;
            curAddr <= bus.addr;
            wdata <= bus.data;
            rdata <= '0;                            // Upper bytes stay zero
        end
        if (state == memTransfer) begin
            if (ls)
                ram[curAddr] <= wdata[{byteIdx, 3'b000} +: 8];
            else
                rdata[{byteIdx, 3'b000} +: 8] <= ram[curAddr];
            curAddr <= curAddr + 1'b1;
        end
    end

endmodule

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  logic reqStore,
    input  addrT reqAddr,
    input  dataT reqData,
    input  lenT  reqLen,
    input  tagT  reqTag,
    output logic reqReady,
    output logic respValid,
    output dataT respData,
    output tagT  respTag
);
    memReqIf reqBus ();
    memBusIf memBus ();

    loadStoreQueue queue (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqStore (reqStore),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqLen   (reqLen),
        .reqTag   (reqTag),
        .reqReady (reqReady),
        .respValid(respValid),
        .respData (respData),
        .respTag  (respTag),
        .cacheReq (reqBus.queue)
    );

    dataCache cache (
        .clk    (clk),
        .rst    (rst),
        .cpuSide(reqBus.cache),
        .memSide(memBus.cache)
    );

    memController memCtrl (
        .clk(clk),
        .rst(rst),
        .bus(memBus.ctrl)
    );

endmodule

// ==== testbench/memSubsystem_sva.sv ====
`timescale 1ns/1ps

module memSubsystem_sva (
    input logic clk,
    input logic rst,
    input logic cpuEn,
    input logic cpuReady,
    input logic cpuDone,
    input logic memEn,
    input logic memBusy
);
    int failCount = 0;              // Seen by the response monitor
    logic held;                     // Request taken, not yet answered

    always_ff @(posedge clk) begin
        if (rst)
            held <= 1'b0;
        else if (cpuEn && cpuReady)
            held <= 1'b1;
        else if (cpuDone)
            held <= 1'b0;
    end

    busyAfterStart: assert property (@(posedge clk) disable iff (rst)
        memEn |=> (memBusy && !memEn))
        else begin
            failCount++;
            $error("memory start not answered by busy or wider than one cycle");
        end

    doneOneCycle: assert property (@(posedge clk) disable iff (rst) cpuDone |=> !cpuDone)
        else begin
            failCount++;
            $error("cache done wider than one cycle");
        end

    readyLowWhileHeld: assert property (@(posedge clk) disable iff (rst) held |-> !cpuReady)
        else begin
            failCount++;
            $error("cache ready high while a request is held");
        end

endmodule

bind dataCache memSubsystem_sva handshakeChecks (
    .clk     (clk),
    .rst     (rst),
    .cpuEn   (cpuSide.en),
    .cpuReady(cpuSide.ready),
    .cpuDone (cpuSide.done),
    .memEn   (memSide.en),
    .memBusy (memSide.busy)
);

// ==== testbench/memSubsystem_tb.sv ====
`timescale 1ns/1ps

module memSubsystem_tb import memPkg::*; ();
    typedef struct packed {
        logic store;
        addrT addr;
        dataT data;
        lenT len;
        tagT tag;
    } opT;

    localparam int TableLen = 16;
    localparam int RandomCount = 40;
    localparam int TotalReqs = TableLen + RandomCount;
    localparam int TimeoutCycles = TotalReqs * 20;

    logic clk;
    logic rst;
    logic reqValid;
    logic reqStore;
    addrT reqAddr;
    dataT reqData;
    lenT reqLen;
    tagT reqTag;
    logic reqReady;
    logic respValid;
    dataT respData;
    tagT respTag;

    logic [7:0] refMem [MemBytes];
    dataT expData [$];
    tagT expTag [$];
    int respCount = 0;
    int seed = 32'hdfacb853;
    logic fullSeen = 1'b0;

    // store, addr, data, len, tag
    opT ops [TableLen] = '{
        '{1'b0, 17'h00100, 32'h0000_0000, 2'd3, 4'h0},     // Never written
        '{1'b0, 17'h00101, 32'h0000_0000, 2'd0, 4'h1},
        '{1'b1, 17'h00200, 32'hdead_beef, 2'd3, 4'h2},
        '{1'b0, 17'h00200, 32'h0000_0000, 2'd3, 4'h3},     // Refill
        '{1'b0, 17'h00200, 32'h0000_0000, 2'd3, 4'h4},     // Hit
        '{1'b1, 17'h00201, 32'h0000_005a, 2'd0, 4'h5},
        '{1'b1, 17'h00202, 32'h0000_1234, 2'd1, 4'h6},
        '{1'b0, 17'h00201, 32'h0000_0000, 2'd0, 4'h7},
        '{1'b0, 17'h00202, 32'h0000_0000, 2'd1, 4'h8},
        '{1'b0, 17'h00200, 32'h0000_0000, 2'd3, 4'h9},
        '{1'b1, 17'h00600, 32'hcafe_f00d, 2'd3, 4'ha},     // Same index, other tag
        '{1'b0, 17'h00600, 32'h0000_0000, 2'd3, 4'hb},
        '{1'b0, 17'h00200, 32'h0000_0000, 2'd3, 4'hc},
        '{1'b0, 17'h00603, 32'h0000_0000, 2'd0, 4'hd},
        '{1'b1, 17'h00203, 32'h0000_0077, 2'd0, 4'he},     // Store miss
        '{1'b0, 17'h00200, 32'h0000_0000, 2'd3, 4'hf}
    };

    memSubsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkData(dataT expected);
        if (respData !== expected) begin
            $display("FAIL %0t respData got %h expected %h", $time, respData, expected);
            abortRun();
        end
    endtask

    task automatic checkTag(tagT expected);
        if (respTag !== expected) begin
            $display("FAIL %0t respTag got %h expected %h", $time, respTag, expected);
            abortRun();
        end
    endtask

    //////////////////////////////
    // Reference memory
    function automatic dataT expectedLoad(addrT addr, lenT len);
        dataT val;
        val = '0;
        for (int i = 0; i <= int'(len); i++)
            val = val | (dataT'(refMem[addr + addrT'(i)]) << (8 * i));   // Little endian
        return val;
    endfunction

    task automatic writeRefMem(addrT addr, dataT data, lenT len);
        for (int i = 0; i <= int'(len); i++)
            refMem[addr + addrT'(i)] = 8'(data >> (8 * i));
    endtask

    task automatic issueRequest(opT op);
        if (op.store) begin
            expData.push_back('0);
            writeRefMem(op.addr, op.data, op.len);
        end else begin
            expData.push_back(expectedLoad(op.addr, op.len));
        end
        expTag.push_back(op.tag);
        reqValid = 1'b1;
        reqStore = op.store;
        reqAddr = op.addr;
        reqData = op.data;
        reqLen = op.len;
        reqTag = op.tag;
        while (!reqReady) begin
            fullSeen = 1'b1;                // Queue full
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic issueRandomMix(int count);
        opT op;
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            op.store = r[0];
            case (r[2:1])
                2'd0: op.len = 2'd0;
                2'd1: op.len = 2'd1;
                default: op.len = 2'd3;
            endcase
            op.addr = addrT'({r[8:3], 2'b00});     // 64 words
            if (op.len == 2'd0)
                op.addr[1:0] = r[10:9];
            else if (op.len == 2'd1)
                op.addr[1] = r[9];
            op.data = $random(seed);
            op.tag = tagT'(i);
            issueRequest(op);
        end
    endtask

    //////////////////////////////
    // Response monitor
    always @(negedge clk) begin
        if (uut.cache.handshakeChecks.failCount != 0) begin
            $display("Handshake assertion in the data cache failed before %0t", $time);
            abortRun();
        end else if (!rst && respValid) begin
            if (expData.size() == 0) begin
                $display("Response with tag %h at %0t had no pending request", respTag, $time);
                abortRun();
            end else begin
                checkData(expData.pop_front());
                checkTag(expTag.pop_front());
                respCount++;
            end
        end
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout with %0d of %0d responses received", respCount, TotalReqs);
        abortRun();
    end

    initial begin
        addrT a;
        rst = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqAddr = '0;
        reqData = '0;
        reqLen = '0;
        reqTag = '0;
        a = '0;
        repeat (MemBytes) begin
            refMem[a] = 8'h00;
            a = a + 1'b1;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < TableLen; i++)
            issueRequest(ops[i]);
        issueRandomMix(RandomCount);
        wait (respCount == TotalReqs);
        repeat (10) @(posedge clk);         // Catch stray responses
        if (!fullSeen) begin
            $display("reqReady never dropped, so the queue was never filled");
            abortRun();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
verilog/memPkg.sv
verilog/memReqIf.sv
verilog/memBusIf.sv
verilog/loadStoreQueue.sv
verilog/dataCache.sv
verilog/memController.sv
verilog/memSubsystem.sv
testbench/memSubsystem_sva.sv
testbench/memSubsystem_tb.sv

// ==== Makefile ====
TOP = memSubsystem_tb

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
